// File: verilog.f
+incdir+include
design/pipe_pkg.sv
design/hazard_detect.sv
design/ex_busy.sv
design/pipeline_control.sv
design/pipe_stages.sv
design/pipe_ctrl_top.sv
tests/tb_pipe_ctrl.sv

// File: Bender.yml
package:
  name: pipe_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/pipe_pkg.sv
      - design/hazard_detect.sv
      - design/ex_busy.sv
      - design/pipeline_control.sv
      - design/pipe_stages.sv
      - design/pipe_ctrl_top.sv
  - target: test
    files:
      - tests/tb_pipe_ctrl.sv

// File: tests/tb_pipe_ctrl.sv
module tb_pipe_ctrl
  import pipe_pkg::*;
();

  localparam int N_INSTR   = 300;
  localparam int WD_CYCLES = 20 * N_INSTR * MULDIV_CYCLES;

  // one accepted instruction as the model sees it
  typedef struct packed {
    instr_t instr;
    logic   killed;    // younger than a jump, never retires
    logic   dep_load;  // reads rd of the load accepted just before
  } exp_t;

  logic   clk;
  logic   rst;
  logic   in_valid_i;
  instr_t in_instr_i;
  logic   in_ready_o;
  logic   mem_ready_i;
  logic   retire_valid_o;
  instr_t retire_instr_o;

  logic [15:0]      lfsr_state = 16'd91;
  exp_t             exp_q[$];
  int               cyc;
  int               live_out;      // accepted, not killed, not yet retired
  int               kill_left;
  int               last_ret_cyc;
  logic             have_ret;
  logic             prev_load_live;
  logic [REG_W-1:0] prev_rd;

  pipe_ctrl_top DUT (
    .clk            (clk),
    .rst            (rst),
    .in_valid_i     (in_valid_i),
    .in_instr_i     (in_instr_i),
    .in_ready_o     (in_ready_o),
    .mem_ready_i    (mem_ready_i),
    .retire_valid_o (retire_valid_o),
    .retire_instr_o (retire_instr_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = next_lfsr(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic instr_t make_instr(input int idx);
    instr_t ins;
    logic [2:0] cls;
    ins     = '0;
    ins.tag = idx[TAG_W-1:0];
    cls     = 3'(take_bits(3));
    ins.rd  = REG_W'(take_bits(2));  // x0..x3 so hazards show up often
    ins.rs1 = REG_W'(take_bits(2));
    ins.rs2 = REG_W'(take_bits(2));
    case (cls)
      3'd0, 3'd1: ins.is_load = 1'b1;
      3'd2:       ins.is_muldiv = 1'b1;
      3'd3:       ins.is_jump = 1'b1;
      default:    ;  // plain alu op
    endcase
    return ins;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic accept_instr(input instr_t ins);
    exp_t e;
    e.instr    = ins;
    e.killed   = (kill_left > 0);
    e.dep_load = 1'b0;
    if (e.killed) begin
      kill_left--;
    end else begin
      e.dep_load = prev_load_live && (prev_rd != '0) &&
                   ((ins.rs1 == prev_rd) || (ins.rs2 == prev_rd));
      if (ins.is_jump) kill_left = 2;  // the two behind it are in IF and ID
      live_out++;
    end
    prev_load_live = !e.killed && ins.is_load;
    prev_rd        = ins.rd;
    exp_q.push_back(e);
  endtask

  task automatic check_retire();
    exp_t head;
    int   gap;
    if (retire_valid_o) begin
      while (exp_q.size() > 0 && exp_q[0].killed) begin
        void'(exp_q.pop_front());
      end
      if (exp_q.size() == 0) check_val("retire_valid_o", 0, 1);
      head = exp_q.pop_front();
      check_val("retire_instr_o", head.instr, retire_instr_o);
      gap = cyc - last_ret_cyc;
      // bubbles of a mul/div go ahead of it
      if (head.instr.is_muldiv && have_ret && gap < MULDIV_CYCLES) begin
        check_val("mul/div retire gap", MULDIV_CYCLES, gap);
      end
      if (head.dep_load && gap < 2) check_val("load-use retire gap", 2, gap);
      last_ret_cyc = cyc;
      have_ret     = 1'b1;
      live_out--;
    end
  endtask

  initial begin
    int     n_acc;
    logic   acc_now;
    instr_t cur;
    n_acc          = 0;
    cyc            = 0;
    live_out       = 0;
    kill_left      = 0;
    last_ret_cyc   = 0;
    have_ret       = 1'b0;
    prev_load_live = 1'b0;
    prev_rd        = '0;
    rst            = 1'b1;
    in_valid_i     = 1'b0;
    in_instr_i     = '0;
    mem_ready_i    = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_val("in_ready_o", 1, in_ready_o);
    check_val("retire_valid_o", 0, retire_valid_o);
    cur = make_instr(0);
    @(posedge clk);
    in_valid_i <= 1'b1;
    in_instr_i <= cur;
    while (!(n_acc == N_INSTR && live_out == 0)) begin
      @(negedge clk);
      check_retire();
      acc_now = in_valid_i && in_ready_o;  // holds until the next edge
      @(posedge clk);
      cyc++;
      mem_ready_i <= (take_bits(2) != '0);  // ready 3 out of 4
      if (acc_now) begin
        accept_instr(cur);
        n_acc++;
        if (n_acc < N_INSTR) begin
          cur = make_instr(n_acc);
          in_instr_i <= cur;
        end else begin
          in_valid_i <= 1'b0;
        end
      end
    end
    // nothing else may come out once everything has drained
    repeat (8) begin
      @(negedge clk);
      check_retire();
    end
    $display("TB PASSED");
    $finish;
  end

  initial begin
    repeat (WD_CYCLES + 4) @(posedge clk);
    $display("watchdog expired, retirement stalled with %0d instructions outstanding",
             live_out);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule

// File: design/pipe_ctrl_top.sv
module pipe_ctrl_top
  import pipe_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   in_valid_i,
  input  instr_t in_instr_i,
  output logic   in_ready_o,
  input  logic   mem_ready_i,
  output logic   retire_valid_o,
  output instr_t retire_instr_o
);

  stage_t                id_stage;
  stage_t                ex_stage;
  stage_t                mem_stage;
  stage_t                wb_stage;
  logic                  load_use;
  logic                  jump;
  logic                  muldiv_busy;
  logic                  mem_wait;
  pipe_req_t             req;
  logic [NUM_STAGES-1:0] stall;
  logic [NUM_STAGES-1:0] flush;

  // only a load in MEM depends on the data bus
  assign mem_wait = mem_stage.valid && mem_stage.instr.is_load && !mem_ready_i;

  assign req = '{
    load_use:    load_use,
    jump:        jump,
    muldiv_busy: muldiv_busy,
    mem_wait:    mem_wait
  };

  assign in_ready_o     = !stall[STG_IF];
  assign retire_valid_o = wb_stage.valid;
  assign retire_instr_o = wb_stage.instr;

  pipe_stages u_stages (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_instr_i  (in_instr_i),
    .stall_i     (stall),
    .flush_i     (flush),
    .id_stage_o  (id_stage),
    .ex_stage_o  (ex_stage),
    .mem_stage_o (mem_stage),
    .wb_stage_o  (wb_stage)
  );

  hazard_detect u_hazard (
    .id_stage_i (id_stage),
    .ex_stage_i (ex_stage),
    .load_use_o (load_use),
    .jump_o     (jump)
  );

  ex_busy u_ex_busy (
    .clk        (clk),
    .rst        (rst),
    .ex_stage_i (ex_stage),
    .mem_wait_i (mem_wait),
    .busy_o     (muldiv_busy)
  );

  pipeline_control u_ctrl (
    .req_i   (req),
    .stall_o (stall),
    .flush_o (flush)
  );

endmodule

// File: design/pipe_stages.sv
`include "pipe_defs.svh"

module pipe_stages
  import pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  input  instr_t                in_instr_i,
  input  logic [NUM_STAGES-1:0] stall_i,
  input  logic [NUM_STAGES-1:0] flush_i,
  output stage_t                id_stage_o,
  output stage_t                ex_stage_o,
  output stage_t                mem_stage_o,
  output stage_t                wb_stage_o
);

  stage_t stg_q [NUM_STAGES];  // indexed by STG_*
  stage_t stg_d [NUM_STAGES];  // what each stage takes when it advances

  assign stg_d[STG_IF] = '{valid: in_valid_i, instr: in_instr_i};

  for (genvar i = 1; i < NUM_STAGES; i++) begin : g_link
    assign stg_d[i] = stg_q[i-1];
  end

  // flush beats stall, only valid is cleared on a bubble
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_STAGES; i++) begin
      if (rst || flush_i[i]) begin
        stg_q[i].valid <= 1'b0;
      end else if (!stall_i[i]) begin
        stg_q[i] <= stg_d[i];
      end
    end
  end

  assign id_stage_o  = stg_q[STG_ID];
  assign ex_stage_o  = stg_q[STG_EX];
  assign mem_stage_o = stg_q[STG_MEM];
  assign wb_stage_o  = stg_q[STG_WB];  // retire port

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    (stall_i & flush_i) == '0)
    else $error("%s pipe: stall %b and flush %b overlap",
                `PIPE_DEPTH_STR, stall_i, flush_i);

  // a held instruction stays put and stays valid
  for (genvar i = 0; i < NUM_STAGES; i++) begin : g_chk
    a_hold: assert property (@(posedge clk) disable iff (rst)
      stall_i[i] && stg_q[i].valid |=>
        stg_q[i].valid && (stg_q[i].instr.tag == $past(stg_q[i].instr.tag)))
      else $error("%s pipe: stage %0d changed while stalled", `PIPE_DEPTH_STR, i);
  end

endmodule

// File: design/pipeline_control.sv
module pipeline_control
  import pipe_pkg::*;
(
  input  pipe_req_t             req_i,
  output logic [NUM_STAGES-1:0] stall_o,
  output logic [NUM_STAGES-1:0] flush_o
);

  // later stages win, a stalled stage freezes everything behind it
  always_comb begin
    stall_o = '0;
    flush_o = '0;
    if (req_i.mem_wait) begin
      // load in MEM waits, WB drains into a bubble
      stall_o = MEM_WAIT_STALL;
      flush_o = MEM_WAIT_FLUSH;
    end else if (req_i.muldiv_busy) begin
      stall_o = MULDIV_STALL;
      flush_o = MULDIV_FLUSH;
    end else if (req_i.jump) begin
      // jump moves on, ID and EX take bubbles
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (req_i.load_use) begin
      stall_o = LOAD_USE_STALL;
      flush_o = LOAD_USE_FLUSH;
    end
  end

endmodule

// File: design/ex_busy.sv
`include "pipe_defs.svh"

module ex_busy
  import pipe_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  stage_t ex_stage_i,
  input  logic   mem_wait_i,
  output logic   busy_o
);

  logic                ex_md;
  logic                started_q;  // counter holds the op now in EX
  logic [MD_CNT_W-1:0] cnt_q;
  logic [MD_CNT_W-1:0] remain;     // busy cycles left, this one included

  assign ex_md  = ex_stage_i.valid && ex_stage_i.instr.is_muldiv;
  assign remain = started_q ? cnt_q : MD_CNT_W'(MULDIV_CYCLES - 1);
  assign busy_o = ex_md && (remain != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      started_q <= 1'b0;
      cnt_q     <= '0;
    end else if (ex_md) begin
      if (mem_wait_i) begin
        // whole EX frozen, no progress
        started_q <= 1'b1;
        cnt_q     <= remain;
      end else if (remain != '0) begin
        started_q <= 1'b1;
        cnt_q     <= remain - 1'b1;
      end else begin
        started_q <= 1'b0;  // op moves to MEM at this edge
      end
    end
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (rst)
    cnt_q <= MULDIV_CYCLES - 1)
    else $error("%s pipe: mul/div counter at %0d", `PIPE_DEPTH_STR, cnt_q);

  // counter state must never outlive the op it was loaded for
  a_cnt_owner: assert property (@(posedge clk) disable iff (rst)
    started_q |-> ex_md)
    else $error("%s pipe: mul/div counter active with no mul/div in EX", `PIPE_DEPTH_STR);

endmodule

// File: design/hazard_detect.sv
module hazard_detect
  import pipe_pkg::*;
(
  input  stage_t id_stage_i,
  input  stage_t ex_stage_i,
  output logic   load_use_o,
  output logic   jump_o
);

  logic [REG_W-1:0] ex_rd;
  logic             ex_load;
  logic             rs1_hit;
  logic             rs2_hit;
  logic [2:0]       ex_class;

  assign ex_rd = ex_stage_i.instr.rd;

  // x0 never produces a hazard
  assign ex_load = ex_stage_i.valid && ex_stage_i.instr.is_load && (ex_rd != '0);

  // source operands of the instruction waiting in ID
  assign rs1_hit = (id_stage_i.instr.rs1 == ex_rd);
  assign rs2_hit = (id_stage_i.instr.rs2 == ex_rd);

  assign load_use_o = ex_load && id_stage_i.valid && (rs1_hit || rs2_hit);
  assign jump_o     = ex_stage_i.valid && ex_stage_i.instr.is_jump;  // resolved in EX

  assign ex_class = {
    ex_stage_i.instr.is_load,
    ex_stage_i.instr.is_muldiv,
    ex_stage_i.instr.is_jump
  };

  // the priority table assumes a jump is never also a load or a mul/div
  always_comb begin
    if (load_use_o || jump_o) begin
      assert final ($onehot0(ex_class))
        else $error("hazard_detect: EX tag %0h has class flags %b",
                    ex_stage_i.instr.tag, ex_class);
    end
  end

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

  localparam int NUM_STAGES = 5;

  // bit positions in the stall and flush vectors, WB is the msb
  localparam int STG_IF  = 0;
  localparam int STG_ID  = 1;
  localparam int STG_EX  = 2;
  localparam int STG_MEM = 3;
  localparam int STG_WB  = 4;

  localparam int TAG_W         = 8;
  localparam int REG_W         = 5;
  localparam int MULDIV_CYCLES = 4;                       // cycles a mul/div sits in EX
  localparam int MD_CNT_W      = $clog2(MULDIV_CYCLES);

  // stall / flush codes per request, order is WB MEM EX ID IF
  localparam logic [NUM_STAGES-1:0] MEM_WAIT_STALL = 5'b01111;
  localparam logic [NUM_STAGES-1:0] MEM_WAIT_FLUSH = 5'b10000;
  localparam logic [NUM_STAGES-1:0] MULDIV_STALL   = 5'b00111;
  localparam logic [NUM_STAGES-1:0] MULDIV_FLUSH   = 5'b01000;
  localparam logic [NUM_STAGES-1:0] JUMP_STALL     = 5'b00000;
  localparam logic [NUM_STAGES-1:0] JUMP_FLUSH     = 5'b00110;  // kill the two younger ones
  localparam logic [NUM_STAGES-1:0] LOAD_USE_STALL = 5'b00011;
  localparam logic [NUM_STAGES-1:0] LOAD_USE_FLUSH = 5'b00100;  // one bubble into EX

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic             is_load;    // writes rd in MEM, may wait on memory
    logic             is_muldiv;
    logic             is_jump;
  } instr_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
  } stage_t;

  typedef struct packed {
    logic load_use;
    logic jump;
    logic muldiv_busy;
    logic mem_wait;
  } pipe_req_t;

endpackage

// File: include/pipe_defs.svh
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// stage count as printed in assertion messages
`define PIPE_DEPTH_STR "5-stage"

`endif
